//--- rtl/CpuPkg.sv
package CpuPkg;

    // ********************
    // widths
    // ********************
    localparam int wordWidth = 16;
    localparam int addrWidth = 12;
    localparam int regAddrWidth = 3;
    localparam int opcodeWidth = 4;
    localparam int funcWidth = 9;
    localparam int numRegs = 1 << regAddrWidth;
    localparam int memDepth = 1 << addrWidth;

    // ********************
    // encodings
    // ********************
    typedef enum logic [opcodeWidth-1:0] {
        LOAD     = 4'd0,
        STORE    = 4'd1,
        JUMP     = 4'd2,
        JUMPPAGE = 4'd3,
        BRANCHZ  = 4'd4,
        ADDI     = 4'd5,
        RTYPE    = 4'd8,
        HALT     = 4'd15
    } Opcode;

    // function code sits in the low three bits of the RTYPE function field
    typedef enum logic [2:0] {
        NOP      = 3'd0,
        MOVETO   = 3'd1,
        MOVEFROM = 3'd2,
        ADD      = 3'd3,
        SUB      = 3'd4,
        AND      = 3'd5,
        OR       = 3'd6,
        NOT      = 3'd7
    } FuncCode;

    typedef enum logic [2:0] {
        ALU_PASSA,
        ALU_PASSB,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_NOTB
    } AluOp;

    typedef enum logic [1:0] {
        SRCB_REG,
        SRCB_ONE,
        SRCB_IMM
    } AluSrcB;

    typedef enum logic [1:0] {
        PC_ALU,
        PC_PAGE,
        PC_ABS
    } PcSrc;

    // ********************
    // instruction layout
    // ********************
    typedef struct packed {
        logic [opcodeWidth-1:0] opcode;
        logic [addrWidth-1:0]   imm;
    } ImmFields;

    typedef struct packed {
        logic [opcodeWidth-1:0]  opcode;
        logic [regAddrWidth-1:0] regIdx;
        logic [funcWidth-1:0]    func;
    } RegFields;

    // both views cover the same 16 bits, the immediate overlaps regIdx and func
    typedef union packed {
        ImmFields i;
        RegFields r;
    } Instruction;

    typedef struct packed {
        logic   pcWrite;
        logic   branch;
        logic   iOrD;
        logic   irWrite;
        logic   regDst;
        logic   moveTo;
        logic   dataFromMem;
        logic   regWrite;
        logic   aluSrcA;
        AluSrcB aluSrcB;
        AluOp   aluOp;
        PcSrc   pcSrc;
        logic   memWrite;
    } ControlWord;

endpackage

//--- rtl/Alu.sv
`timescale 1ns/1ns

module Alu (
    input  logic [CpuPkg::wordWidth-1:0] a,
    input  logic [CpuPkg::wordWidth-1:0] b,
    input  CpuPkg::AluOp                 op,
    output logic [CpuPkg::wordWidth-1:0] res,
    output logic                         zero
);

    always_comb begin
        case (op)
            CpuPkg::ALU_PASSA: res = a;
            CpuPkg::ALU_PASSB: res = b;
            CpuPkg::ALU_ADD:   res = a + b;
            // two's complement subtraction wraps below zero
            CpuPkg::ALU_SUB:   res = a - b;
            CpuPkg::ALU_AND:   res = a & b;
            CpuPkg::ALU_OR:    res = a | b;
            CpuPkg::ALU_NOTB:  res = ~b;
            default:           res = a;
        endcase
    end

    // BRANCHZ reads this with PASSA on the accumulator
    assign zero = (res == '0);

endmodule

//--- rtl/RegisterFile.sv
`timescale 1ns/1ns

module RegisterFile (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [CpuPkg::regAddrWidth-1:0] readAdr,
    input  logic [CpuPkg::regAddrWidth-1:0] writeAdr,
    input  logic [CpuPkg::wordWidth-1:0]    writeData,
    input  logic                            regWrite,
    output logic [CpuPkg::wordWidth-1:0]    accData,
    output logic [CpuPkg::wordWidth-1:0]    readData
);

    logic [CpuPkg::wordWidth-1:0] regs [CpuPkg::numRegs];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < CpuPkg::numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite) begin
            regs[writeAdr] <= writeData;
        end
    end

    // R0 is the accumulator and has its own port
    assign accData = regs[0];
    assign readData = regs[readAdr];

endmodule

//--- rtl/CpuDatapath.sv
`timescale 1ns/1ns

module CpuDatapath (
    input  logic                         clk,
    input  logic                         rst,
    input  CpuPkg::ControlWord           ctrl,
    input  logic [CpuPkg::wordWidth-1:0] memData,
    output logic [CpuPkg::addrWidth-1:0] memAdr,
    output logic [CpuPkg::wordWidth-1:0] memWriteData,
    output CpuPkg::Opcode                opcode,
    output CpuPkg::FuncCode              funcCode
);

    localparam int extWidth = CpuPkg::wordWidth - CpuPkg::addrWidth;
    localparam int pageWidth = CpuPkg::addrWidth - CpuPkg::funcWidth;

    logic [CpuPkg::addrWidth-1:0]    pc;
    logic [CpuPkg::addrWidth-1:0]    pcNext;
    logic                            pcLoad;
    CpuPkg::Instruction              ir;
    logic [CpuPkg::wordWidth-1:0]    mdr;
    logic [CpuPkg::wordWidth-1:0]    aReg;
    logic [CpuPkg::wordWidth-1:0]    bReg;
    logic [CpuPkg::wordWidth-1:0]    aluOut;
    logic [CpuPkg::wordWidth-1:0]    aluA;
    logic [CpuPkg::wordWidth-1:0]    aluB;
    logic [CpuPkg::wordWidth-1:0]    aluRes;
    logic                            zero;
    logic [CpuPkg::wordWidth-1:0]    immExt;
    logic [CpuPkg::wordWidth-1:0]    accData;
    logic [CpuPkg::wordWidth-1:0]    readData;
    logic [CpuPkg::regAddrWidth-1:0] writeAdr;
    logic [CpuPkg::wordWidth-1:0]    writeData;

    // ********************
    // state registers
    // ********************
    // the branch condition is resolved here so the controller never sees zero
    assign pcLoad = ctrl.pcWrite | (ctrl.branch & zero);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
            ir <= '0;
            mdr <= '0;
            aReg <= '0;
            bReg <= '0;
            aluOut <= '0;
        end else begin
            if (pcLoad)
                pc <= pcNext;
            if (ctrl.irWrite)
                ir <= memData;
            mdr <= memData;
            aReg <= accData;
            bReg <= readData;
            aluOut <= aluRes;
        end
    end

    // ********************
    // operand selection
    // ********************
    assign immExt = {{extWidth{ir.i.imm[CpuPkg::addrWidth-1]}}, ir.i.imm};
    assign aluA = ctrl.aluSrcA ? {{extWidth{1'b0}}, pc} : aReg;

    always_comb begin
        case (ctrl.aluSrcB)
            CpuPkg::SRCB_REG: aluB = bReg;
            CpuPkg::SRCB_ONE: aluB = 1;
            CpuPkg::SRCB_IMM: aluB = immExt;
            default:          aluB = '0;
        endcase
    end

    Alu alu (
        .a(aluA),
        .b(aluB),
        .op(ctrl.aluOp),
        .res(aluRes),
        .zero(zero)
    );

    always_comb begin
        case (ctrl.pcSrc)
            CpuPkg::PC_PAGE: pcNext = {pc[CpuPkg::addrWidth-1 -: pageWidth], ir.r.func};
            CpuPkg::PC_ABS:  pcNext = ir.i.imm;
            default:         pcNext = aluRes[CpuPkg::addrWidth-1:0];
        endcase
    end

    assign writeAdr = ctrl.moveTo ? ir.r.regIdx : '0;
    assign writeData = ctrl.dataFromMem ? mdr : aluOut;

    RegisterFile regFile (
        .clk(clk),
        .rst(rst),
        .readAdr(ir.r.regIdx),
        .writeAdr(writeAdr),
        .writeData(writeData),
        .regWrite(ctrl.regWrite),
        .accData(accData),
        .readData(readData)
    );

    assign memAdr = ctrl.iOrD ? ir.i.imm : pc;
    assign memWriteData = aReg;
    assign opcode = CpuPkg::Opcode'(ir.i.opcode);
    assign funcCode = CpuPkg::FuncCode'(ir.r.func[2:0]);

    // a fetch is followed by decode, which must leave pc and IR alone
    pcOnlyInFetch: assert property (@(posedge clk) disable iff (rst)
        (ctrl.irWrite && ctrl.pcWrite) |=> !(ctrl.irWrite || ctrl.pcWrite || ctrl.branch));

endmodule

//--- rtl/CpuController.sv
`timescale 1ns/1ns

module CpuController (
    input  logic               clk,
    input  logic               rst,
    input  CpuPkg::Opcode      opcode,
    input  CpuPkg::FuncCode    funcCode,
    output CpuPkg::ControlWord ctrl,
    output logic               halted
);

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        MEMREAD,
        LOADWB,
        MEMWRITE,
        EXEC,
        ALUWB,
        HALTED
    } State;

    State state;
    State nextState;

    always_ff @(posedge clk) begin
        if (rst)
            state <= FETCH;
        else
            state <= nextState;
    end

    // ********************
    // next state
    // ********************
    always_comb begin
        nextState = state;
        case (state)
            FETCH:    nextState = DECODE;
            DECODE: begin
                case (opcode)
                    CpuPkg::LOAD:     nextState = MEMREAD;
                    CpuPkg::STORE:    nextState = MEMWRITE;
                    CpuPkg::JUMP,
                    CpuPkg::JUMPPAGE,
                    CpuPkg::BRANCHZ,
                    CpuPkg::ADDI,
                    CpuPkg::RTYPE:    nextState = EXEC;
                    // unknown opcodes stop the machine like HALT
                    default:          nextState = HALTED;
                endcase
            end
            MEMREAD:  nextState = LOADWB;
            LOADWB:   nextState = FETCH;
            MEMWRITE: nextState = FETCH;
            EXEC: begin
                if (opcode == CpuPkg::ADDI || opcode == CpuPkg::RTYPE)
                    nextState = ALUWB;
                else
                    nextState = FETCH;
            end
            ALUWB:    nextState = FETCH;
            HALTED:   nextState = HALTED;
            default:  nextState = FETCH;
        endcase
    end

    // ********************
    // control word
    // ********************
    always_comb begin
        ctrl = '0;
        case (state)
            FETCH: begin
                // pc + 1 goes straight from the ALU into the pc
                ctrl.irWrite = 1'b1;
                ctrl.pcWrite = 1'b1;
                ctrl.aluSrcA = 1'b1;
                ctrl.aluSrcB = CpuPkg::SRCB_ONE;
                ctrl.aluOp = CpuPkg::ALU_ADD;
                ctrl.pcSrc = CpuPkg::PC_ALU;
            end
            MEMREAD: ctrl.iOrD = 1'b1;
            LOADWB: begin
                ctrl.dataFromMem = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            MEMWRITE: begin
                ctrl.iOrD = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            EXEC: begin
                case (opcode)
                    CpuPkg::JUMP: begin
                        ctrl.pcWrite = 1'b1;
                        ctrl.pcSrc = CpuPkg::PC_ABS;
                    end
                    CpuPkg::JUMPPAGE: begin
                        ctrl.pcWrite = 1'b1;
                        ctrl.pcSrc = CpuPkg::PC_PAGE;
                    end
                    CpuPkg::BRANCHZ: begin
                        ctrl.branch = 1'b1;
                        ctrl.aluOp = CpuPkg::ALU_PASSA;
                        ctrl.pcSrc = CpuPkg::PC_ABS;
                    end
                    CpuPkg::ADDI: begin
                        ctrl.aluSrcB = CpuPkg::SRCB_IMM;
                        ctrl.aluOp = CpuPkg::ALU_ADD;
                    end
                    CpuPkg::RTYPE: begin
                        case (funcCode)
                            CpuPkg::MOVEFROM: ctrl.aluOp = CpuPkg::ALU_PASSB;
                            CpuPkg::ADD:      ctrl.aluOp = CpuPkg::ALU_ADD;
                            CpuPkg::SUB:      ctrl.aluOp = CpuPkg::ALU_SUB;
                            CpuPkg::AND:      ctrl.aluOp = CpuPkg::ALU_AND;
                            CpuPkg::OR:       ctrl.aluOp = CpuPkg::ALU_OR;
                            CpuPkg::NOT:      ctrl.aluOp = CpuPkg::ALU_NOTB;
                            default:          ctrl.aluOp = CpuPkg::ALU_PASSA;
                        endcase
                    end
                    default: ;
                endcase
            end
            ALUWB: begin
                // nop writes nothing, moveTo writes Ri instead of R0
                ctrl.regWrite = !(opcode == CpuPkg::RTYPE && funcCode == CpuPkg::NOP);
                ctrl.moveTo = (opcode == CpuPkg::RTYPE && funcCode == CpuPkg::MOVETO);
            end
            default: ;
        endcase
    end

    assign halted = (state == HALTED);

    // a memory write only ever comes from a STORE straight after its decode
    memWriteOnlyInMemWrite: assert property (@(posedge clk) disable iff (rst)
        ctrl.memWrite |-> state == MEMWRITE && $past(state) == DECODE
            && opcode == CpuPkg::STORE);

    noRegAndMemWrite: assert property (@(posedge clk) disable iff (rst)
        !(ctrl.regWrite && ctrl.memWrite));

endmodule

//--- rtl/Memory.sv
`timescale 1ns/1ns

module Memory (
    input  logic                         clk,
    input  logic [CpuPkg::addrWidth-1:0] memAdr,
    input  logic [CpuPkg::wordWidth-1:0] memWriteData,
    input  logic                         memWrite,
    input  logic                         progValid,
    input  logic [CpuPkg::addrWidth-1:0] progAdr,
    input  logic [CpuPkg::wordWidth-1:0] progData,
    output logic [CpuPkg::wordWidth-1:0] memData
);

    logic [CpuPkg::wordWidth-1:0] mem [CpuPkg::memDepth];

    // instruction and data share this array, reads are combinational
    assign memData = mem[memAdr];

    // ********************
    // write ports
    // ********************
    always_ff @(posedge clk) begin
        if (progValid)
            mem[progAdr] <= progData;
        else if (memWrite)
            mem[memAdr] <= memWriteData;
    end

    // loading happens only while the CPU sits in reset
    noWriteCollision: assert property (@(posedge clk)
        !(progValid && memWrite));

endmodule

//--- rtl/MulticycleCpu.sv
`timescale 1ns/1ns

module MulticycleCpu (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         progValid,
    input  logic [CpuPkg::addrWidth-1:0] progAdr,
    input  logic [CpuPkg::wordWidth-1:0] progData,
    output logic                         storeValid,
    output logic [CpuPkg::addrWidth-1:0] storeAdr,
    output logic [CpuPkg::wordWidth-1:0] storeData,
    output logic                         halted
);

    CpuPkg::ControlWord           ctrl;
    CpuPkg::Opcode                opcode;
    CpuPkg::FuncCode              funcCode;
    logic [CpuPkg::addrWidth-1:0] memAdr;
    logic [CpuPkg::wordWidth-1:0] memData;
    logic [CpuPkg::wordWidth-1:0] memWriteData;

    CpuController controller (
        .clk(clk),
        .rst(rst),
        .opcode(opcode),
        .funcCode(funcCode),
        .ctrl(ctrl),
        .halted(halted)
    );

    CpuDatapath datapath (
        .clk(clk),
        .rst(rst),
        .ctrl(ctrl),
        .memData(memData),
        .memAdr(memAdr),
        .memWriteData(memWriteData),
        .opcode(opcode),
        .funcCode(funcCode)
    );

    Memory memory (
        .clk(clk),
        .memAdr(memAdr),
        .memWriteData(memWriteData),
        .memWrite(ctrl.memWrite),
        .progValid(progValid),
        .progAdr(progAdr),
        .progData(progData),
        .memData(memData)
    );

    // every CPU write is visible outside in the same cycle
    assign storeValid = ctrl.memWrite;
    assign storeAdr = memAdr;
    assign storeData = memWriteData;

endmodule

//--- test/IsaModel.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// executes image one instruction at a time and queues every store the CPU has to make
task automatic runIsaModel();
    logic [CpuPkg::wordWidth-1:0]    mem [CpuPkg::memDepth];
    logic [CpuPkg::wordWidth-1:0]    regs [CpuPkg::numRegs];
    logic [CpuPkg::addrWidth-1:0]    pc;
    logic [CpuPkg::wordWidth-1:0]    inst;
    logic [CpuPkg::regAddrWidth-1:0] idx;
    logic [CpuPkg::addrWidth-1:0]    field;
    logic [CpuPkg::wordWidth-1:0]    immExt;
    logic                            running;
    StoreRec                         rec;
    mem = image;
    foreach (regs[r])
        regs[r] = '0;
    pc = '0;
    running = 1'b1;
    modelSteps = 0;
    expStores.delete();
    while (running && modelSteps < maxSteps) begin
        inst = mem[pc];
        idx = inst[11:9];
        field = inst[11:0];
        immExt = {{(CpuPkg::wordWidth - CpuPkg::addrWidth){field[11]}}, field};
        // the pc has already moved past the instruction when it executes
        pc = pc + 1'b1;
        modelSteps++;
        case (inst[15:12])
            CpuPkg::LOAD:     regs[0] = mem[field];
            CpuPkg::STORE: begin
                mem[field] = regs[0];
                rec.adr = field;
                rec.data = regs[0];
                expStores.push_back(rec);
            end
            CpuPkg::JUMP:     pc = field;
            CpuPkg::JUMPPAGE: pc = {pc[11:9], inst[8:0]};
            CpuPkg::BRANCHZ: begin
                if (regs[0] == '0)
                    pc = field;
            end
            CpuPkg::ADDI:     regs[0] = regs[0] + immExt;
            CpuPkg::RTYPE: begin
                case (inst[2:0])
                    CpuPkg::MOVETO:   regs[idx] = regs[0];
                    CpuPkg::MOVEFROM: regs[0] = regs[idx];
                    CpuPkg::ADD:      regs[0] = regs[0] + regs[idx];
                    CpuPkg::SUB:      regs[0] = regs[0] - regs[idx];
                    CpuPkg::AND:      regs[0] = regs[0] & regs[idx];
                    CpuPkg::OR:       regs[0] = regs[0] | regs[idx];
                    CpuPkg::NOT:      regs[0] = ~regs[idx];
                    default: ;
                endcase
            end
            // HALT and every unused opcode stop the machine
            default: running = 1'b0;
        endcase
    end
endtask

`endif

//--- test/MulticycleCpuTb.sv
`timescale 1ns/1ns

module MulticycleCpuTb;

    localparam int dataBase = 'h800;
    localparam int storeBase = 'hc00;
    localparam int numData = 16;
    localparam int maxSteps = 4096;

    typedef struct packed {
        logic [CpuPkg::addrWidth-1:0] adr;
        logic [CpuPkg::wordWidth-1:0] data;
    } StoreRec;

    logic                         clk;
    logic                         rst;
    logic                         progValid;
    logic [CpuPkg::addrWidth-1:0] progAdr;
    logic [CpuPkg::wordWidth-1:0] progData;
    logic                         storeValid;
    logic [CpuPkg::addrWidth-1:0] storeAdr;
    logic [CpuPkg::wordWidth-1:0] storeData;
    logic                         halted;

    logic [CpuPkg::wordWidth-1:0] image [CpuPkg::memDepth];
    StoreRec                      expStores [$];
    logic [CpuPkg::addrWidth-1:0] freshAdr;
    logic [31:0]                  rngState = 32'd88854;
    int                           codeLen;
    int                           modelSteps;
    int                           cycles = 0;
    int                           mismatches = 0;
    int                           otherErrors = 0;

    `include "IsaModel.svh"

    MulticycleCpu dut (
        .clk(clk),
        .rst(rst),
        .progValid(progValid),
        .progAdr(progAdr),
        .progData(progData),
        .storeValid(storeValid),
        .storeAdr(storeAdr),
        .storeData(storeData),
        .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
        cycles <= cycles + 1;

    // ********************
    // program assembly
    // ********************
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [15:0] nextRandom();
        rngState = xorshift(rngState);
        return rngState[15:0];
    endfunction

    function automatic void place(input CpuPkg::Opcode op, input int field);
        image[codeLen] = {op, CpuPkg::addrWidth'(field)};
        codeLen++;
    endfunction

    function automatic void regOp(input CpuPkg::FuncCode fc, input int idx);
        // the upper function bits are random and only bits 2:0 select the operation
        place(CpuPkg::RTYPE, {idx[2:0], 6'(nextRandom()), fc});
    endfunction

    function automatic void storeFresh();
        place(CpuPkg::STORE, int'(freshAdr));
        freshAdr++;
    endfunction

    task automatic buildProgram();
        CpuPkg::FuncCode fc;
        // words that are never loaded decode as HALT tagged with their address
        foreach (image[a])
            image[a] = {CpuPkg::HALT, CpuPkg::addrWidth'(a)};
        for (int k = 0; k < numData; k++)
            image[dataBase + k] = nextRandom();
        // a large R7 and a small data word make one subtraction wrap
        image[dataBase + 7][CpuPkg::wordWidth-1] = 1'b1;
        image[dataBase + 8] = image[dataBase + 8] & 16'h00ff;
        codeLen = 0;
        freshAdr = CpuPkg::addrWidth'(storeBase);
        for (int k = 0; k < 4; k++) begin
            place(CpuPkg::LOAD, dataBase + k);
            storeFresh();
        end
        for (int k = 0; k < CpuPkg::numRegs; k++) begin
            place(CpuPkg::LOAD, dataBase + k);
            regOp(CpuPkg::MOVETO, k);
        end
        for (int k = 0; k < CpuPkg::numRegs; k++) begin
            regOp(CpuPkg::MOVEFROM, k);
            storeFresh();
        end
        regOp(CpuPkg::NOP, 0);
        storeFresh();
        // every ALU operation from ADD to NOT comes round more than once
        for (int k = 0; k < 12; k++) begin
            place(CpuPkg::LOAD, dataBase + nextRandom() % numData);
            fc = CpuPkg::FuncCode'(CpuPkg::ADD + k % 5);
            regOp(fc, 1 + nextRandom() % 7);
            storeFresh();
        end
        place(CpuPkg::LOAD, dataBase + 8);
        regOp(CpuPkg::SUB, 7);
        storeFresh();
        place(CpuPkg::ADDI, nextRandom() | 16'h0800);
        storeFresh();
        place(CpuPkg::ADDI, nextRandom() & 16'h07ff);
        storeFresh();
        // R0 minus a copy of itself is zero, so this branch skips one store
        regOp(CpuPkg::MOVETO, 1);
        regOp(CpuPkg::SUB, 1);
        place(CpuPkg::BRANCHZ, codeLen + 2);
        storeFresh();
        storeFresh();
        place(CpuPkg::ADDI, 1 + nextRandom() % 'h7ff);
        place(CpuPkg::BRANCHZ, codeLen + 2);
        storeFresh();
        storeFresh();
        place(CpuPkg::JUMP, codeLen + 2);
        storeFresh();
        storeFresh();
        // bits 11:9 of the field are nonzero and must not reach the pc
        place(CpuPkg::JUMPPAGE, {3'(nextRandom()) | 3'b100, 9'(codeLen + 2)});
        storeFresh();
        storeFresh();
        place(CpuPkg::HALT, 0);
        storeFresh();
    endtask

    // ********************
    // store checking
    // ********************
    storeExpected: assert property (@(negedge clk) disable iff (rst)
        storeValid |-> expStores.size() != 0)
    else begin
        $display("Unexpected store to address %h at time %0t", storeAdr, $time);
        otherErrors++;
    end

    storeMatches: assert property (@(negedge clk) disable iff (rst)
        (storeValid && expStores.size() != 0) |->
            (storeAdr == expStores[0].adr && storeData == expStores[0].data))
    else begin
        $display("Mismatch at time %0t: expected store [%h] = %h, got [%h] = %h",
            $time, expStores[0].adr, expStores[0].data, storeAdr, storeData);
        mismatches++;
    end

    noStoreWhenHalted: assert property (@(negedge clk) disable iff (rst)
        halted |-> !storeValid)
    else begin
        $display("A store happened after the CPU halted at time %0t", $time);
        otherErrors++;
    end

    // the checked store leaves the queue on the edge that ends its cycle
    always @(posedge clk) begin
        if (!rst && storeValid && expStores.size() != 0)
            void'(expStores.pop_front());
    end

    initial begin
        int                           loadWords;
        int                           resetCycles;
        int                           limit;
        logic [CpuPkg::addrWidth-1:0] adr;
        rst = 1'b1;
        progValid = 1'b0;
        progAdr = '0;
        progData = '0;
        buildProgram();
        runIsaModel();
        loadWords = codeLen + numData;
        resetCycles = (loadWords + 1 > 10) ? loadWords + 1 : 10;
        limit = 10 + loadWords + 4 * modelSteps + 50;
        for (int k = 0; k < resetCycles; k++) begin
            @(posedge clk);
            #1;
            if (k < loadWords) begin
                if (k < codeLen)
                    adr = CpuPkg::addrWidth'(k);
                else
                    adr = CpuPkg::addrWidth'(dataBase + k - codeLen);
                progValid = 1'b1;
                progAdr = adr;
                progData = image[adr];
            end else begin
                progValid = 1'b0;
            end
        end
        @(posedge clk);
        #1;
        rst = 1'b0;
        while (!halted && cycles < limit) begin
            @(posedge clk);
            #1;
        end
        if (!halted) begin
            $display("Timeout: the CPU did not halt within %0d cycles", limit);
            otherErrors++;
        end
        // a store slipping out after HALT would still be seen here
        repeat (5) @(posedge clk);
        #1;
        allStoresSeen: assert (expStores.size() == 0)
        else begin
            $display("%0d expected stores were missing when the CPU halted", expStores.size());
            otherErrors++;
        end
        $display("Errors: %0d store mismatches, %0d other failures", mismatches, otherErrors);
        if (mismatches + otherErrors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- MulticycleCpu.f
+incdir+test
rtl/CpuPkg.sv
rtl/Alu.sv
rtl/RegisterFile.sv
rtl/CpuDatapath.sv
rtl/CpuController.sv
rtl/Memory.sv
rtl/MulticycleCpu.sv
test/MulticycleCpuTb.sv

//--- Makefile
# Verilator build and run of the multicycle CPU testbench

VERILATOR   ?= verilator
TOP         ?= MulticycleCpuTb
FILELIST    ?= MulticycleCpu.f
OBJ_DIR     ?= obj_dir
BUILD_FLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS  ?= --lint-only --timing -Wall
PASS_TEXT   ?= Regression passed
SOURCES     := $(wildcard rtl/*.sv test/*.sv test/*.svh)

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
